// File: icache.f
common/icache_pkg.sv
icache/icache_ram.sv
icache/icache_line_fill.sv
icache/icache_ctrl.sv
source/icache_regs.sv
source/icache_top.sv
testbench/axi_mem_model.sv
testbench/tb_icache.sv

// File: Makefile
# Verilator build and run of the instruction cache testbench

BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f icache.f --top-module tb_icache -Mdir $(BUILD) -o sim_icache

run: compile
	./$(BUILD)/sim_icache | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

   localparam int INDEX_W        = 4;
   localparam int OFFSET_W       = 2;
   localparam int LINE_LSB       = OFFSET_W + icache_pkg::BYTES_W;
   localparam int TAG_LSB        = LINE_LSB + INDEX_W;
   localparam int TIMEOUT_CYCLES = 4000;  // about twice the full run
   localparam logic [31:0] PATTERN = 32'h5a5a_0000;
   localparam logic [31:0] ALIAS   = 32'(1) << TAG_LSB;  // same index with the next tag
   localparam logic [31:0] LINE_A  = 32'h0000_1040;
   localparam logic [31:0] ADDR_X  = 32'h0000_2084;
   localparam logic [31:0] LINE_B  = 32'h0000_30a8;
   localparam logic [31:0] LINE_E  = 32'h0000_7ac0;
   localparam logic [icache_pkg::REG_OFF_W-1:0] REG_UNMAPPED = 'd5;

   logic                clk;
   logic                reset;
   icache_pkg::wb_req_t cpu_req;
   icache_pkg::wb_rsp_t cpu_rsp;
   icache_pkg::wb_req_t reg_req;
   icache_pkg::wb_rsp_t reg_rsp;
   icache_pkg::axi_ar_t axi_ar;
   logic                axi_arready;
   icache_pkg::axi_r_t  axi_r;
   logic                axi_rready;
   logic                err_arm;
   int                  ar_count;

   integer seed   = 32'h1675_d2f4;
   int     errors = 0;
   int     checks = 0;
   int     cycles = 0;

   // expected state of the direct mapped cache
   logic [31:0]          ref_tag [2**INDEX_W];
   logic [2**INDEX_W-1:0] ref_valid;
   logic                 ref_enable;
   logic                 retry_next;  // armed burst is fetched twice
   int                   exp_hits;
   int                   exp_misses;
   int                   exp_ar;

   icache_top #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) UUT (
      .clk_i(clk), .reset(reset),
      .cpu_req_i(cpu_req), .cpu_rsp_o(cpu_rsp),
      .reg_req_i(reg_req), .reg_rsp_o(reg_rsp),
      .axi_ar_o(axi_ar), .axi_arready_i(axi_arready),
      .axi_r_i(axi_r), .axi_rready_o(axi_rready)
   );

   axi_mem_model u_mem (
      .clk_i(clk), .err_arm_i(err_arm),
      .ar_i(axi_ar), .arready_o(axi_arready),
      .rready_i(axi_rready), .r_o(axi_r), .ar_count_o(ar_count)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) cycles <= cycles + 1;

   initial begin
      wait (cycles >= TIMEOUT_CYCLES);
      $display("ERROR: timeout after %0d cycles, a bus transfer never finished", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   // each burst asks for one whole line of incrementing words
   always @(negedge clk) begin
      if (axi_ar.arvalid && axi_arready) begin
         compare_value("axi_ar.arlen", 32'(axi_ar.arlen), 32'(2**OFFSET_W - 1));
         compare_value("axi_ar.arsize", 32'(axi_ar.arsize), 32'(icache_pkg::BYTES_W));
         compare_value("axi_ar.arburst", 32'(axi_ar.arburst), 32'h1);
      end
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   task automatic require_true(input logic cond, input string what);
      checks++;
      assert (cond === 1'b1) else begin
         $display("ERROR: %s at %0t", what, $time);
         errors++;
      end
   endtask

   // one classic transfer held until ack or err
   task automatic bus_access(input logic to_regs, input logic we, input logic [31:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat,
                             output logic got_err);
      icache_pkg::wb_req_t req;
      icache_pkg::wb_rsp_t rsp;
      req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: '1};
      @(posedge clk);
      #1;
      if (to_regs) begin
         reg_req = req;
      end else begin
         cpu_req = req;
      end
      do begin
         @(posedge clk);
         #1;
         rsp = to_regs ? reg_rsp : cpu_rsp;
      end while (!rsp.ack && !rsp.err);
      cpu_req = '0;
      reg_req = '0;
      rdat    = rsp.dat;
      got_err = rsp.err;
   endtask

   task automatic wb_read(input logic [31:0] adr);
      logic [31:0]        rdat;
      logic               got_err;
      logic [INDEX_W-1:0] idx;
      logic [31:0]        tag;
      idx = adr[TAG_LSB-1:LINE_LSB];
      tag = adr >> TAG_LSB;
      if (ref_enable && ref_valid[idx] && ref_tag[idx] == tag) begin
         exp_hits++;
      end else begin
         exp_misses++;
         exp_ar         = exp_ar + (retry_next ? 2 : 1);
         ref_valid[idx] = 1'b1;
         ref_tag[idx]   = tag;
         retry_next     = 1'b0;
      end
      bus_access(1'b0, 1'b0, adr, '0, rdat, got_err);
      require_true(!got_err, $sformatf("cache read of %h ended with err", adr));
      compare_value("cpu_rsp.dat", rdat, adr ^ PATTERN);
      compare_value("ar_count", ar_count, exp_ar);
   endtask

   task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
      logic [31:0] rdat;
      logic        got_err;
      bus_access(1'b0, 1'b1, adr, dat, rdat, got_err);
      require_true(got_err, "cache port write did not end with err");
   endtask

   task automatic reg_read(input logic [icache_pkg::REG_OFF_W-1:0] off,
                           input logic [31:0] exp, input string name);
      logic [31:0] rdat;
      logic        got_err;
      bus_access(1'b1, 1'b0, {off, 2'b00}, '0, rdat, got_err);
      require_true(!got_err, {"register read of ", name, " ended with err"});
      compare_value(name, rdat, exp);
   endtask

   task automatic reg_write(input logic [icache_pkg::REG_OFF_W-1:0] off,
                            input logic [31:0] dat);
      logic [31:0] rdat;
      logic        got_err;
      bus_access(1'b1, 1'b1, {off, 2'b00}, dat, rdat, got_err);
      require_true(!got_err, "register write ended with err");
   endtask

   task automatic verify_counters();
      reg_read(icache_pkg::REG_HITS, exp_hits, "HITS");
      reg_read(icache_pkg::REG_MISSES, exp_misses, "MISSES");
   endtask

   task automatic reset_state();
      require_true(!cpu_rsp.ack && !cpu_rsp.err, "cache port responds right after reset");
      require_true(!axi_ar.arvalid, "arvalid is high right after reset");
      require_true(!axi_rready, "rready is high right after reset");
      reg_read(icache_pkg::REG_HITS, 0, "HITS");
      reg_read(icache_pkg::REG_MISSES, 0, "MISSES");
      reg_read(icache_pkg::REG_CTRL, 1, "CTRL");
   endtask

   task automatic miss_then_hits();
      for (int i = 0; i < 4; i++) begin
         wb_read(LINE_A + 32'(i * 4));  // one refill and then three hits
      end
      verify_counters();
   endtask

   task automatic conflict_eviction();
      logic [31:0] adr;
      wb_read(ADDR_X);
      wb_read(ADDR_X + ALIAS);
      wb_read(ADDR_X);
      verify_counters();
      for (int i = 0; i < 20; i++) begin
         adr = 32'({$random(seed)}) & 32'h0000_03fc;  // small range so that some hit
         wb_read(adr);
      end
      verify_counters();
   endtask

   task automatic invalidate_and_disable();
      wb_read(LINE_A);
      wb_read(LINE_A);             // hit for sure
      reg_write(icache_pkg::REG_CTRL, 32'h3);
      ref_valid = '0;
      wb_read(LINE_A);
      reg_write(icache_pkg::REG_CTRL, 32'h0);
      ref_enable = 1'b0;
      wb_read(LINE_B);
      wb_read(LINE_B);
      reg_write(icache_pkg::REG_CTRL, 32'h1);
      ref_enable = 1'b1;
      reg_read(icache_pkg::REG_CTRL, 1, "CTRL");
      wb_read(LINE_B);
      verify_counters();
   endtask

   task automatic slave_error_retry();
      @(posedge clk);
      #1;
      err_arm = 1'b1;
      @(posedge clk);
      #1;
      err_arm    = 1'b0;
      retry_next = 1'b1;
      wb_read(LINE_E);
      wb_read(LINE_E + 32'hc);       // rest of the line from the second burst
      verify_counters();
   endtask

   task automatic illegal_accesses();
      logic [31:0] rdat;
      logic        got_err;
      wb_write(LINE_A, 32'hdead_beef);
      verify_counters();
      bus_access(1'b1, 1'b0, {REG_UNMAPPED, 2'b00}, '0, rdat, got_err);
      require_true(got_err, "unmapped register offset did not end with err");
   endtask

   initial begin
      reset      = 1'b1;
      cpu_req    = '0;
      reg_req    = '0;
      err_arm    = 1'b0;
      ref_valid  = '0;
      ref_enable = 1'b1;
      retry_next = 1'b0;
      exp_hits   = 0;
      exp_misses = 0;
      exp_ar     = 0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;

      reset_state();
      miss_then_hits();
      conflict_eviction();
      invalidate_and_disable();
      slave_error_retry();
      illegal_accesses();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: testbench/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
   parameter int MAX_DELAY = 3  // wait cycles before arready and between beats
) (
   input  logic                clk_i,
   input  logic                err_arm_i,  // next burst answers with slverr
   input  icache_pkg::axi_ar_t ar_i,
   output logic                arready_o,
   input  logic                rready_i,
   output icache_pkg::axi_r_t  r_o,
   output int                  ar_count_o
);

   localparam logic [31:0] PATTERN = 32'h5a5a_0000;

   integer seed = 32'h1675_d2f4;
   logic   err_pending = 1'b0;

   // arm input is sampled on the edge, outputs change 1 ns later
   task automatic step();
      @(posedge clk_i);
      if (err_arm_i) begin
         err_pending = 1'b1;
      end
      #1;
   endtask

   task automatic random_wait();
      int n;
      n = {$random(seed)} % (MAX_DELAY + 1);
      repeat (n) step();
   endtask

   task automatic serve_burst();
      logic [31:0] addr;
      int          last;
      logic        bad;
      random_wait();
      addr      = ar_i.araddr;
      last      = ar_i.arlen;
      arready_o = 1'b1;
      step();                        // address handshake
      arready_o   = 1'b0;
      ar_count_o  = ar_count_o + 1;
      bad         = err_pending;
      err_pending = 1'b0;
      for (int i = 0; i <= last; i++) begin
         random_wait();
         while (!rready_i) begin
            step();
         end
         r_o.rvalid = 1'b1;
         r_o.rdata  = (addr + 32'(i << icache_pkg::BYTES_W)) ^ PATTERN;
         r_o.rresp  = bad ? 2'b10 : 2'b00;
         r_o.rlast  = (i == last);
         if (bad) begin
            r_o.rdata = ~r_o.rdata;  // garbage that the retry must overwrite
         end
         step();                     // beat accepted on this edge
         r_o = '0;
      end
   endtask

   initial begin
      arready_o  = 1'b0;
      r_o        = '0;
      ar_count_o = 0;
      forever begin
         step();
         if (ar_i.arvalid) begin
            serve_burst();
         end
      end
   end

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
   parameter int INDEX_W  = 4,
   parameter int OFFSET_W = 2
) (
   input  logic                clk_i,
   input  logic                reset,

   input  icache_pkg::wb_req_t cpu_req_i,
   output icache_pkg::wb_rsp_t cpu_rsp_o,

   input  icache_pkg::wb_req_t reg_req_i,
   output icache_pkg::wb_rsp_t reg_rsp_o,

   output icache_pkg::axi_ar_t axi_ar_o,
   input  logic                axi_arready_i,
   input  icache_pkg::axi_r_t  axi_r_i,
   output logic                axi_rready_o
);

   localparam int LINE_LSB = OFFSET_W + icache_pkg::BYTES_W;
   localparam int TAG_W    = icache_pkg::ADDR_W - INDEX_W - LINE_LSB;
   localparam int LADDR_W  = icache_pkg::ADDR_W - LINE_LSB;

   typedef logic [TAG_W-1:0]              tag_entry_t;
   typedef logic [icache_pkg::DATA_W-1:0] data_entry_t;

   icache_pkg::cache_cfg_t        cfg;
   icache_pkg::cache_evt_t        evt;

   logic [INDEX_W-1:0]            tag_addr;
   logic                          tag_we;
   logic [TAG_W-1:0]              tag_wdata;
   tag_entry_t                    tag_rdata;

   logic [INDEX_W+OFFSET_W-1:0]   ctrl_data_addr;
   logic [INDEX_W+OFFSET_W-1:0]   data_addr;
   data_entry_t                   data_rdata;

   logic                          replace_valid;
   logic [LADDR_W-1:0]            replace_addr;
   logic                          replace;
   logic                          fill_valid;
   logic [OFFSET_W-1:0]           fill_word;
   logic [icache_pkg::DATA_W-1:0] fill_data;

   // fill engine owns the data memory address while a line loads
   assign data_addr = replace ? {replace_addr[INDEX_W-1:0], fill_word} : ctrl_data_addr;

   icache_ctrl #(
      .INDEX_W  (INDEX_W),
      .OFFSET_W (OFFSET_W)
   ) u_ctrl (
      .clk_i           (clk_i),
      .reset           (reset),
      .cpu_req_i       (cpu_req_i),
      .cpu_rsp_o       (cpu_rsp_o),
      .cfg_i           (cfg),
      .evt_o           (evt),
      .tag_addr_o      (tag_addr),
      .tag_we_o        (tag_we),
      .tag_wdata_o     (tag_wdata),
      .tag_rdata_i     (tag_rdata),
      .data_addr_o     (ctrl_data_addr),
      .data_rdata_i    (data_rdata),
      .replace_valid_o (replace_valid),
      .replace_addr_o  (replace_addr),
      .replace_i       (replace)
   );

   icache_line_fill #(
      .ADDR_W   (icache_pkg::ADDR_W),
      .OFFSET_W (OFFSET_W)
   ) u_line_fill (
      .clk_i           (clk_i),
      .reset           (reset),
      .replace_valid_i (replace_valid),
      .replace_addr_i  (replace_addr),
      .replace_o       (replace),
      .fill_valid_o    (fill_valid),
      .fill_word_o     (fill_word),
      .fill_data_o     (fill_data),
      .axi_ar_o        (axi_ar_o),
      .axi_arready_i   (axi_arready_i),
      .axi_r_i         (axi_r_i),
      .axi_rready_o    (axi_rready_o)
   );

   icache_ram #(
      .DEPTH_W (INDEX_W),
      .entry_t (tag_entry_t)
   ) u_tag_ram (
      .clk_i   (clk_i),
      .addr_i  (tag_addr),
      .we_i    (tag_we),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata)
   );

   icache_ram #(
      .DEPTH_W (INDEX_W + OFFSET_W),
      .entry_t (data_entry_t)
   ) u_data_ram (
      .clk_i   (clk_i),
      .addr_i  (data_addr),
      .we_i    (fill_valid),
      .wdata_i (fill_data),
      .rdata_o (data_rdata)
   );

   icache_regs u_regs (
      .clk_i     (clk_i),
      .reset     (reset),
      .reg_req_i (reg_req_i),
      .reg_rsp_o (reg_rsp_o),
      .cfg_o     (cfg),
      .evt_i     (evt)
   );

endmodule

// File: source/icache_regs.sv
`timescale 1ns/1ps

module icache_regs (
   input  logic                   clk_i,
   input  logic                   reset,

   input  icache_pkg::wb_req_t    reg_req_i,
   output icache_pkg::wb_rsp_t    reg_rsp_o,

   output icache_pkg::cache_cfg_t cfg_o,
   input  icache_pkg::cache_evt_t evt_i
);

   logic                                pend_q;  // request sampled, answer next edge
   logic                                ack_q;
   logic                                err_q;
   logic [icache_pkg::DATA_W-1:0]       dat_q;
   logic                                enable_q;
   logic                                inval_q;
   logic [icache_pkg::DATA_W-1:0]       hits_q;
   logic [icache_pkg::DATA_W-1:0]       misses_q;

   logic [icache_pkg::REG_OFF_W-1:0]    word;
   logic                                mapped;
   logic [icache_pkg::DATA_W-1:0]       rd_data;

   assign word = reg_req_i.adr[icache_pkg::ADDR_W-1:icache_pkg::BYTES_W];

   always_comb begin
      mapped  = 1'b1;
      rd_data = '0;
      case (word)
         icache_pkg::REG_CTRL:   rd_data[0] = enable_q;  // invalidate reads back 0
         icache_pkg::REG_STATUS: rd_data[0] = evt_i.busy;
         icache_pkg::REG_HITS:   rd_data    = hits_q;
         icache_pkg::REG_MISSES: rd_data    = misses_q;
         default:                mapped     = 1'b0;
      endcase
   end

   assign reg_rsp_o = '{ack: ack_q, err: err_q, dat: dat_q};
   assign cfg_o     = '{enable: enable_q, invalidate: inval_q};

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         pend_q   <= 1'b0;
         ack_q    <= 1'b0;
         err_q    <= 1'b0;
         enable_q <= 1'b1;
         inval_q  <= 1'b0;
         hits_q   <= '0;
         misses_q <= '0;
      end else begin
         ack_q   <= 1'b0;
         err_q   <= 1'b0;
         inval_q <= 1'b0;
         if (evt_i.hit && (hits_q != '1)) begin
            hits_q <= hits_q + 1'b1;  // saturates
         end
         if (evt_i.miss && (misses_q != '1)) begin
            misses_q <= misses_q + 1'b1;
         end
         if (pend_q) begin
            pend_q <= 1'b0;
            ack_q  <= mapped;
            err_q  <= !mapped;
            if (reg_req_i.we && mapped) begin
               case (word)
                  icache_pkg::REG_CTRL: begin
                     if (reg_req_i.sel[0]) begin
                        enable_q <= reg_req_i.dat[0];
                        inval_q  <= reg_req_i.dat[1];
                     end
                  end
                  icache_pkg::REG_HITS:   hits_q   <= '0;  // clear wins over a hit
                  icache_pkg::REG_MISSES: misses_q <= '0;
                  default: ;
               endcase
            end
         end else if (reg_req_i.cyc && reg_req_i.stb && !ack_q && !err_q) begin
            pend_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (pend_q) begin
         dat_q <= rd_data;
      end
   end

endmodule

// File: icache/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
   parameter int  INDEX_W  = 4,
   parameter int  OFFSET_W = 2,
   localparam int LINE_LSB = OFFSET_W + icache_pkg::BYTES_W,
   localparam int TAG_LSB  = LINE_LSB + INDEX_W,
   localparam int TAG_W    = icache_pkg::ADDR_W - TAG_LSB
) (
   input  logic                             clk_i,
   input  logic                             reset,

   input  icache_pkg::wb_req_t              cpu_req_i,
   output icache_pkg::wb_rsp_t              cpu_rsp_o,

   input  icache_pkg::cache_cfg_t           cfg_i,
   output icache_pkg::cache_evt_t           evt_o,

   output logic [INDEX_W-1:0]               tag_addr_o,
   output logic                             tag_we_o,
   output logic [TAG_W-1:0]                 tag_wdata_o,
   input  logic [TAG_W-1:0]                 tag_rdata_i,

   output logic [INDEX_W+OFFSET_W-1:0]      data_addr_o,
   input  logic [icache_pkg::DATA_W-1:0]    data_rdata_i,

   output logic                             replace_valid_o,
   output logic [icache_pkg::ADDR_W-LINE_LSB-1:0] replace_addr_o,
   input  logic                             replace_i
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_LOOKUP,
      S_REFILL,
      S_RESPOND
   } ctrl_state_t;

   ctrl_state_t                   state_q;
   logic                          ack_q;
   logic                          err_q;
   logic [icache_pkg::DATA_W-1:0] dat_q;
   logic [2**INDEX_W-1:0]         valid_q;
   logic                          refilled_q;     // line was just loaded for this read
   logic                          inval_pend_q;   // invalidate waiting for idle

   logic                          req_valid;
   logic [INDEX_W-1:0]            req_index;
   logic [OFFSET_W-1:0]           req_offset;
   logic [TAG_W-1:0]              req_tag;
   logic                          tag_hit;
   logic                          lookup_read;

   // the master holds adr until ack, so the memories follow it directly
   assign req_index  = cpu_req_i.adr[TAG_LSB-1:LINE_LSB];
   assign req_offset = cpu_req_i.adr[LINE_LSB-1:icache_pkg::BYTES_W];
   assign req_tag    = cpu_req_i.adr[icache_pkg::ADDR_W-1:TAG_LSB];
   assign req_valid  = cpu_req_i.cyc && cpu_req_i.stb && !ack_q && !err_q;

   assign tag_addr_o  = req_index;
   assign data_addr_o = {req_index, req_offset};  // top swaps in the fill address
   assign tag_wdata_o = req_tag;
   assign tag_we_o    = (state_q == S_REFILL) && !replace_i;

   // disabled cache never hits
   assign tag_hit     = cfg_i.enable && valid_q[req_index] && (tag_rdata_i == req_tag);
   assign lookup_read = (state_q == S_LOOKUP) && !cpu_req_i.we;

   assign replace_valid_o = lookup_read && !refilled_q && !tag_hit;
   assign replace_addr_o  = cpu_req_i.adr[icache_pkg::ADDR_W-1:LINE_LSB];

   assign evt_o = '{
      hit:  lookup_read && !refilled_q && tag_hit,
      miss: lookup_read && !refilled_q && !tag_hit,
      busy: (state_q != S_IDLE)
   };

   assign cpu_rsp_o = '{ack: ack_q, err: err_q, dat: dat_q};

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state_q      <= S_IDLE;
         ack_q        <= 1'b0;
         err_q        <= 1'b0;
         valid_q      <= '0;
         refilled_q   <= 1'b0;
         inval_pend_q <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
         case (state_q)
            S_IDLE: begin
               if (inval_pend_q) begin
                  valid_q      <= '0;
                  inval_pend_q <= 1'b0;
               end
               if (req_valid) begin
                  state_q <= S_LOOKUP;  // memories read on this edge
               end
            end
            S_LOOKUP: begin
               if (cpu_req_i.we || refilled_q || tag_hit) begin
                  refilled_q <= 1'b0;
                  state_q    <= S_RESPOND;
               end else begin
                  state_q <= S_REFILL;
               end
            end
            S_REFILL: begin
               if (!replace_i) begin
                  valid_q[req_index] <= 1'b1;  // tag written on the same edge
                  refilled_q         <= 1'b1;
                  state_q            <= S_LOOKUP;
               end
            end
            default: begin
               ack_q   <= !cpu_req_i.we;
               err_q   <= cpu_req_i.we;  // cache port is read only
               state_q <= S_IDLE;
            end
         endcase
         if (cfg_i.invalidate) begin
            inval_pend_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == S_RESPOND) begin
         dat_q <= data_rdata_i;
      end
   end

endmodule

// File: icache/icache_line_fill.sv
`timescale 1ns/1ps

module icache_line_fill #(
   parameter int  ADDR_W   = 32,
   parameter int  OFFSET_W = 2,
   localparam int LINE_LSB = OFFSET_W + icache_pkg::BYTES_W
) (
   input  logic                          clk_i,
   input  logic                          reset,

   input  logic                          replace_valid_i,  // fill request pulse
   input  logic [ADDR_W-1:LINE_LSB]      replace_addr_i,   // tag and index of the line
   output logic                          replace_o,        // high while busy

   output logic                          fill_valid_o,
   output logic [OFFSET_W-1:0]           fill_word_o,
   output logic [icache_pkg::DATA_W-1:0] fill_data_o,

   output icache_pkg::axi_ar_t           axi_ar_o,
   input  logic                          axi_arready_i,
   input  icache_pkg::axi_r_t            axi_r_i,
   output logic                          axi_rready_o
);

   typedef enum logic [1:0] {
      F_IDLE,
      F_ADDR,
      F_LOAD,
      F_END
   } fill_state_t;

   fill_state_t state_q;
   logic        slave_err_q;  // any beat of the burst had a nonzero rresp
   logic        beat;

   assign beat = (state_q == F_LOAD) && axi_r_i.rvalid;

   // burst request, line aligned and incrementing
   assign axi_ar_o = '{
      arvalid: (state_q == F_ADDR),
      araddr:  {replace_addr_i, {LINE_LSB{1'b0}}},
      arlen:   8'(2**OFFSET_W - 1),
      arsize:  3'(icache_pkg::BYTES_W),
      arburst: 2'b01
   };

   assign axi_rready_o = (state_q == F_LOAD);
   assign replace_o    = (state_q != F_IDLE);

   // every accepted beat goes straight to the data memory
   assign fill_valid_o = beat;
   assign fill_data_o  = axi_r_i.rdata;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state_q     <= F_IDLE;
         slave_err_q <= 1'b0;
         fill_word_o <= '0;
      end else begin
         case (state_q)
            F_IDLE: begin
               slave_err_q <= 1'b0;
               fill_word_o <= '0;
               if (replace_valid_i) begin
                  state_q <= F_ADDR;
               end
            end
            F_ADDR: begin
               slave_err_q <= 1'b0;  // also the restart point after an error
               fill_word_o <= '0;
               if (axi_arready_i) begin
                  state_q <= F_LOAD;
               end
            end
            F_LOAD: begin
               if (beat) begin
                  if (axi_r_i.rresp != 2'b00) begin
                     slave_err_q <= 1'b1;  // burst cannot be cut short, so remember it
                  end
                  if (axi_r_i.rlast) begin
                     state_q <= F_END;   // keep word index on the last beat
                  end else begin
                     fill_word_o <= fill_word_o + OFFSET_W'(1);
                  end
               end
            end
            default: begin
               // one cycle for the last memory write to land
               state_q <= slave_err_q ? F_ADDR : F_IDLE;
            end
         endcase
      end
   end

endmodule

// File: icache/icache_ram.sv
`timescale 1ns/1ps

module icache_ram #(
   parameter int  DEPTH_W = 4,
   parameter type entry_t = logic [31:0]
) (
   input  logic               clk_i,
   input  logic [DEPTH_W-1:0] addr_i,
   input  logic               we_i,
   input  entry_t             wdata_i,
   output entry_t             rdata_o
);

   entry_t mem [2**DEPTH_W];

   always_ff @(posedge clk_i) begin
      rdata_o <= mem[addr_i];       // old contents come out on a write
      if (we_i) begin
         mem[addr_i] <= wdata_i;
      end
   end

endmodule

// File: common/icache_pkg.sv
package icache_pkg;

   localparam int ADDR_W    = 32;                // byte address, front end and axi
   localparam int DATA_W    = 32;                // word width on both sides
   localparam int BYTES_W   = 2;                 // log2 of bytes per word
   localparam int SEL_W     = DATA_W / 8;        // wishbone byte selects
   localparam int REG_OFF_W = ADDR_W - BYTES_W;  // word offset into the register block

   // wishbone classic, master to slave
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
   } wb_req_t;

   // wishbone classic, slave to master
   typedef struct packed {
      logic              ack;
      logic              err;
      logic [DATA_W-1:0] dat;
   } wb_rsp_t;

   // axi read address channel, constant-only signals left out
   typedef struct packed {
      logic              arvalid;
      logic [ADDR_W-1:0] araddr;
      logic [7:0]        arlen;
      logic [2:0]        arsize;
      logic [1:0]        arburst;
   } axi_ar_t;

   // axi read data channel
   typedef struct packed {
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
      logic [1:0]        rresp;
      logic              rlast;
   } axi_r_t;

   localparam logic [REG_OFF_W-1:0] REG_CTRL   = 'd0;  // enable, invalidate
   localparam logic [REG_OFF_W-1:0] REG_STATUS = 'd1;  // busy
   localparam logic [REG_OFF_W-1:0] REG_HITS   = 'd2;
   localparam logic [REG_OFF_W-1:0] REG_MISSES = 'd3;

   // register block to controller
   typedef struct packed {
      logic enable;
      logic invalidate;  // single cycle pulse
   } cache_cfg_t;

   // controller to register block
   typedef struct packed {
      logic hit;   // one pulse per read
      logic miss;  // one pulse per read
      logic busy;
   } cache_evt_t;

endpackage
